// File: hw/icc_pkg.sv
// Shared geometry, state/op encodings and port structs of the L2 maintenance controller; imported where used.
package icc_pkg;

  // ==========================================================================
  // cache geometry defaults
  // ==========================================================================
  parameter int IDX_W      = 4;
  parameter int WAYS       = 4;
  parameter int TAG_W      = 8;
  parameter int WORD_W     = 32;
  parameter int LINE_WORDS = 4;

  // derived field widths
  parameter int WAY_W      = $clog2(WAYS);
  parameter int OFF_W      = $clog2(LINE_WORDS);
  parameter int MID_W      = 3;

  typedef enum logic [1:0] {
    ICC_INV_ALL  = 2'd0,
    ICC_CLN_ALL  = 2'd1,
    ICC_DCA_TAG  = 2'd2,
    ICC_DCA_DATA = 2'd3
  } icc_op_e;

  typedef enum logic [3:0] {
    S_IDLE        = 4'd0,
    S_INV         = 4'd1,
    S_TAG_RD      = 4'd2,
    S_TAG_FLOP    = 4'd3,
    S_STATUS_UPDT = 4'd4,
    S_DIRTY_CHECK = 4'd5,
    S_DATA_RD     = 4'd6,
    S_DATA_FLOP   = 4'd7,
    S_WAIT_RDL    = 4'd8,
    S_DCA_RDY     = 4'd9,
    S_DCA_CMPLT   = 4'd10
  } icc_state_e;

  // ==========================================================================
  // port structs
  // ==========================================================================
  typedef struct packed {
    logic             valid;
    icc_op_e          op;
    logic [WAY_W-1:0] way;
    logic [IDX_W-1:0] index;
    logic [OFF_W-1:0] offset;
    logic [MID_W-1:0] mid;
  } icc_req_t;

  typedef struct packed {
    logic             req;
    logic             write;
    logic [IDX_W-1:0] index;
    logic             clr_vld;
    logic             clr_dirty;
    logic [WAYS-1:0]  way_mask;
  } tag_ram_req_t;

  // read result, held until the next read
  typedef struct packed {
    logic                       grant;
    logic [WAYS-1:0][TAG_W-1:0] tag;
    logic [WAYS-1:0]            vld;
    logic [WAYS-1:0]            dirty;
  } tag_ram_rsp_t;

  typedef struct packed {
    logic             req;
    logic [WAY_W-1:0] way;
    logic [IDX_W-1:0] index;
  } data_ram_req_t;

  // write-back address is tag then set index
  typedef struct packed {
    logic                   valid;
    logic [TAG_W+IDX_W-1:0] addr;
    logic [MID_W-1:0]       mid;
  } rdl_req_t;

  typedef struct packed {
    logic              cmplt;
    logic [WORD_W-1:0] data;
  } dca_rsp_t;

endpackage

// File: hw/icc_req_capture.sv
// Request front end: raises ready for an idle controller and holds the accepted request fields.
`timescale 1ns/1ns

module icc_req_capture #(
  parameter int IDX_W = icc_pkg::IDX_W,
  parameter int WAYS  = icc_pkg::WAYS
) (
  input  logic                      icc_fsm_clk,
  input  logic                      cpurst_b,
  input  icc_pkg::icc_req_t         req,
  input  logic                      idle,
  input  logic                      pipeline_rdy,
  output logic                      ready,
  output icc_pkg::icc_op_e          cur_op,
  output logic [$clog2(WAYS)-1:0]   cur_way,
  output logic [IDX_W-1:0]          cur_index,
  output logic [icc_pkg::OFF_W-1:0] cur_offset,
  output logic [icc_pkg::MID_W-1:0] cur_mid
);
  import icc_pkg::*;

  icc_op_e op_q;

  // accepted in this very cycle
  assign ready = req.valid & idle & pipeline_rdy;

  // the fsm branches on the op during the acceptance cycle,
  // so the incoming op is passed straight through then
  assign cur_op = ready ? req.op : op_q;

  always_ff @(posedge icc_fsm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      op_q <= ICC_INV_ALL;
    else if (ready)
      op_q <= req.op;
  end

  // address fields and master id
  always_ff @(posedge icc_fsm_clk)
  begin
    if (ready)
    begin
      cur_way    <= req.way;
      cur_index  <= req.index;
      cur_offset <= req.offset;
      cur_mid    <= req.mid;
    end
  end

endmodule

// File: hw/icc_fsm.sv
// Sequencing FSM of the maintenance controller, with the set-index sweep counter and last-set detect.
`timescale 1ns/1ns

module icc_fsm #(
  parameter int IDX_W = icc_pkg::IDX_W
) (
  input  logic                icc_fsm_clk,
  input  logic                cpurst_b,
  input  logic                accept,
  input  icc_pkg::icc_op_e    op,
  input  logic                tag_grant,
  input  logic                data_grant,
  input  logic                rdl_ready,
  input  logic                have_dirty,
  output icc_pkg::icc_state_e state,
  output logic [IDX_W-1:0]    sweep_index,
  output logic                idle,
  output logic                sweep_cmplt
);
  import icc_pkg::*;

  icc_state_e next_state;
  logic       is_clean;
  logic       sweep_start;
  logic       index_step;
  logic       last_set;

  assign is_clean = (op == ICC_CLN_ALL);

  // ==========================================================================
  // state register and next state
  // ==========================================================================
  always_ff @(posedge icc_fsm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= S_IDLE;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      S_IDLE:
      begin
        if (accept)
        begin
          case (op)
            ICC_INV_ALL:  next_state = S_INV;
            ICC_DCA_DATA: next_state = S_DATA_RD;
            default:      next_state = S_TAG_RD;
          endcase
        end
      end
      // one granted write per set
      S_INV:
      begin
        if (tag_grant && last_set)
          next_state = S_IDLE;
      end
      S_TAG_RD:
      begin
        if (tag_grant)
          next_state = S_TAG_FLOP;
      end
      // tag result is valid here
      S_TAG_FLOP:    next_state = is_clean ? S_STATUS_UPDT : S_DCA_RDY;
      S_STATUS_UPDT:
      begin
        if (tag_grant)
          next_state = S_DIRTY_CHECK;
      end
      S_DIRTY_CHECK:
      begin
        if (have_dirty)
          next_state = S_DATA_RD;
        else if (last_set)
          next_state = S_IDLE;
        else
          next_state = S_TAG_RD;
      end
      S_DATA_RD:
      begin
        if (data_grant)
          next_state = S_DATA_FLOP;
      end
      S_DATA_FLOP:   next_state = is_clean ? S_WAIT_RDL : S_DCA_RDY;
      // back-pressure just holds here
      S_WAIT_RDL:
      begin
        if (rdl_ready)
          next_state = S_DIRTY_CHECK;
      end
      S_DCA_RDY:     next_state = S_DCA_CMPLT;
      S_DCA_CMPLT:   next_state = S_IDLE;
      default:       next_state = S_IDLE;
    endcase
  end

  // ==========================================================================
  // sweep index
  // ==========================================================================
  assign sweep_start = accept && (op == ICC_INV_ALL || is_clean);
  assign index_step  = (state == S_INV && tag_grant) ||
                       (state == S_DIRTY_CHECK && !have_dirty);
  assign last_set    = &sweep_index;

  always_ff @(posedge icc_fsm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      sweep_index <= '0;
    else if (sweep_start)
      sweep_index <= '0;
    else if (index_step)
      sweep_index <= sweep_index + 1'b1;
  end

  assign idle        = (state == S_IDLE);
  // finishing the all-ones set ends the sweep
  assign sweep_cmplt = index_step && last_set;

endmodule

// File: hw/icc_dirty_scan.sv
// Clean-all way status: tracks valid dirty ways of the set, picks the next one and holds its write-back address.
`timescale 1ns/1ns

module icc_dirty_scan #(
  parameter int WAYS  = icc_pkg::WAYS,
  parameter int TAG_W = icc_pkg::TAG_W,
  parameter int IDX_W = icc_pkg::IDX_W
) (
  input  logic                      icc_fsm_clk,
  input  logic                      cpurst_b,
  input  icc_pkg::icc_state_e       state,
  input  icc_pkg::tag_ram_rsp_t     tag_rsp,
  input  logic                      data_grant,
  input  logic [IDX_W-1:0]          sweep_index,
  input  logic [icc_pkg::MID_W-1:0] mid,
  output logic                      have_dirty,
  output logic [$clog2(WAYS)-1:0]   dirty_way,
  output icc_pkg::rdl_req_t         rdl
);
  import icc_pkg::*;

  localparam int WAY_W = $clog2(WAYS);

  logic [WAYS-1:0]        wb_mask;
  logic                   status_load;
  logic                   way_taken;
  logic [TAG_W+IDX_W-1:0] wb_addr;

  assign status_load = (state == S_STATUS_UPDT);
  assign way_taken   = (state == S_DATA_RD) && data_grant;

  // ways still waiting for write-back in this set
  always_ff @(posedge icc_fsm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      wb_mask <= '0;
    else if (status_load)
      wb_mask <= tag_rsp.vld & tag_rsp.dirty;
    else if (way_taken)
      wb_mask[dirty_way] <= 1'b0;
  end

  assign have_dirty = |wb_mask;

  // fixed priority, highest numbered way first
  always_comb
  begin
    dirty_way = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      if (wb_mask[w])
        dirty_way = WAY_W'(w);
    end
  end

  // ==========================================================================
  // write-back address
  // ==========================================================================
  // tag result is still held from the set read
  always_ff @(posedge icc_fsm_clk)
  begin
    if (way_taken)
      wb_addr <= {tag_rsp.tag[dirty_way], sweep_index};
  end

  assign rdl = '{
    valid: (state == S_WAIT_RDL),
    addr:  wb_addr,
    mid:   mid
  };

endmodule

// File: hw/icc_ram_ctrl.sv
// Tag and data RAM command decode from the controller state and the captured request.
`timescale 1ns/1ns

module icc_ram_ctrl #(
  parameter int IDX_W = icc_pkg::IDX_W,
  parameter int WAYS  = icc_pkg::WAYS
) (
  input  icc_pkg::icc_state_e     state,
  input  icc_pkg::icc_op_e        op,
  input  logic [IDX_W-1:0]        sweep_index,
  input  logic [IDX_W-1:0]        cur_index,
  input  logic [$clog2(WAYS)-1:0] cur_way,
  input  logic [$clog2(WAYS)-1:0] dirty_way,
  output icc_pkg::tag_ram_req_t   tag_req,
  output icc_pkg::data_ram_req_t  data_req
);
  import icc_pkg::*;

  logic             sweep_op;
  logic             tag_wr;
  logic [IDX_W-1:0] ram_index;
  logic [WAYS-1:0]  dca_way_mask;

  // maintenance sweeps walk the counter, dca uses the request index
  assign sweep_op     = (op == ICC_INV_ALL) || (op == ICC_CLN_ALL);
  assign ram_index    = sweep_op ? sweep_index : cur_index;
  assign dca_way_mask = WAYS'(1) << cur_way;

  // invalidate writes in S_INV, clean writes in S_STATUS_UPDT
  assign tag_wr = (state == S_INV) || (state == S_STATUS_UPDT);

  // clean drops dirty across the set while the held read result
  // still carries the dirty bits the write-backs are taken from
  assign tag_req = '{
    req:       (state == S_TAG_RD) || tag_wr,
    write:     tag_wr,
    index:     ram_index,
    clr_vld:   (state == S_INV),
    clr_dirty: tag_wr,
    way_mask:  sweep_op ? {WAYS{1'b1}} : dca_way_mask
  };

  assign data_req = '{
    req:   (state == S_DATA_RD),
    way:   (op == ICC_CLN_ALL) ? dirty_way : cur_way,
    index: ram_index
  };

endmodule

// File: hw/icc_dca_read.sv
// Direct cache access result: forms the tag or data word and registers it for the completion cycle.
`timescale 1ns/1ns

module icc_dca_read #(
  parameter int TAG_W = icc_pkg::TAG_W,
  parameter int WAYS  = icc_pkg::WAYS
) (
  input  logic                                                 icc_fsm_clk,
  input  logic                                                 cpurst_b,
  input  icc_pkg::icc_state_e                                  state,
  input  icc_pkg::icc_op_e                                     op,
  input  logic [$clog2(WAYS)-1:0]                              cur_way,
  input  logic [icc_pkg::OFF_W-1:0]                            cur_offset,
  input  icc_pkg::tag_ram_rsp_t                                tag_rsp,
  input  logic [icc_pkg::LINE_WORDS-1:0][icc_pkg::WORD_W-1:0] data_line,
  output icc_pkg::dca_rsp_t                                    dca
);
  import icc_pkg::*;

  logic [TAG_W-1:0]  way_tag;
  logic [WORD_W-1:0] tag_word;
  logic [WORD_W-1:0] rd_word;
  logic [WORD_W-1:0] rd_word_q;

  // dirty, valid, then tag from bit 0
  assign way_tag  = tag_rsp.tag[cur_way];
  assign tag_word = {{(WORD_W-TAG_W-2){1'b0}},
                     tag_rsp.dirty[cur_way],
                     tag_rsp.vld[cur_way],
                     way_tag};

  assign rd_word = (op == ICC_DCA_TAG) ? tag_word : data_line[cur_offset];

  always_ff @(posedge icc_fsm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      rd_word_q <= '0;
    else if (state == S_DCA_RDY)
      rd_word_q <= rd_word;
  end

  assign dca = '{
    cmplt: (state == S_DCA_CMPLT),
    data:  rd_word_q
  };

endmodule

// File: hw/l2c_icc_top.sv
// Top level of the L2 maintenance controller; connects request capture, FSM, dirty scan, RAM control and DCA read.
`timescale 1ns/1ns

module l2c_icc_top #(
  parameter int IDX_W = icc_pkg::IDX_W,
  parameter int WAYS  = icc_pkg::WAYS,
  parameter int TAG_W = icc_pkg::TAG_W
) (
  input  logic                                                 icc_fsm_clk,
  input  logic                                                 cpurst_b,
  input  icc_pkg::icc_req_t                                    req,
  input  logic                                                 pipeline_rdy,
  input  icc_pkg::tag_ram_rsp_t                                tag_rsp,
  input  logic                                                 data_grant,
  input  logic [icc_pkg::LINE_WORDS-1:0][icc_pkg::WORD_W-1:0] data_line,
  input  logic                                                 rdl_ready,
  output logic                                                 ready,
  output logic                                                 idle,
  output logic                                                 sweep_cmplt,
  output icc_pkg::dca_rsp_t                                    dca,
  output icc_pkg::tag_ram_req_t                                tag_req,
  output icc_pkg::data_ram_req_t                               data_req,
  output icc_pkg::rdl_req_t                                    rdl
);
  import icc_pkg::*;

  icc_state_e              state;
  icc_op_e                 cur_op;
  logic [$clog2(WAYS)-1:0] cur_way;
  logic [IDX_W-1:0]        cur_index;
  logic [OFF_W-1:0]        cur_offset;
  logic [MID_W-1:0]        cur_mid;
  logic [IDX_W-1:0]        sweep_index;
  logic                    have_dirty;
  logic [$clog2(WAYS)-1:0] dirty_way;

  // port structs are sized by the package geometry
  if (IDX_W != icc_pkg::IDX_W || WAYS != icc_pkg::WAYS || TAG_W != icc_pkg::TAG_W)
  begin : g_geom_chk
    $error("l2c_icc_top: geometry parameters differ from icc_pkg");
  end

  icc_req_capture #(.IDX_W(IDX_W), .WAYS(WAYS)) u_req_capture (
    .icc_fsm_clk  (icc_fsm_clk),
    .cpurst_b     (cpurst_b),
    .req          (req),
    .idle         (idle),
    .pipeline_rdy (pipeline_rdy),
    .ready        (ready),
    .cur_op       (cur_op),
    .cur_way      (cur_way),
    .cur_index    (cur_index),
    .cur_offset   (cur_offset),
    .cur_mid      (cur_mid)
  );

  icc_fsm #(.IDX_W(IDX_W)) u_fsm (
    .icc_fsm_clk  (icc_fsm_clk),
    .cpurst_b     (cpurst_b),
    .accept       (ready),
    .op           (cur_op),
    .tag_grant    (tag_rsp.grant),
    .data_grant   (data_grant),
    .rdl_ready    (rdl_ready),
    .have_dirty   (have_dirty),
    .state        (state),
    .sweep_index  (sweep_index),
    .idle         (idle),
    .sweep_cmplt  (sweep_cmplt)
  );

  icc_dirty_scan #(.WAYS(WAYS), .TAG_W(TAG_W), .IDX_W(IDX_W)) u_dirty_scan (
    .icc_fsm_clk  (icc_fsm_clk),
    .cpurst_b     (cpurst_b),
    .state        (state),
    .tag_rsp      (tag_rsp),
    .data_grant   (data_grant),
    .sweep_index  (sweep_index),
    .mid          (cur_mid),
    .have_dirty   (have_dirty),
    .dirty_way    (dirty_way),
    .rdl          (rdl)
  );

  icc_ram_ctrl #(.IDX_W(IDX_W), .WAYS(WAYS)) u_ram_ctrl (
    .state        (state),
    .op           (cur_op),
    .sweep_index  (sweep_index),
    .cur_index    (cur_index),
    .cur_way      (cur_way),
    .dirty_way    (dirty_way),
    .tag_req      (tag_req),
    .data_req     (data_req)
  );

  icc_dca_read #(.TAG_W(TAG_W), .WAYS(WAYS)) u_dca_read (
    .icc_fsm_clk  (icc_fsm_clk),
    .cpurst_b     (cpurst_b),
    .state        (state),
    .op           (cur_op),
    .cur_way      (cur_way),
    .cur_offset   (cur_offset),
    .tag_rsp      (tag_rsp),
    .data_line    (data_line),
    .dca          (dca)
  );

endmodule

// File: sim/icc_tb.sv
// Directed testbench for the L2 maintenance controller with tag and data RAM models.
`timescale 1ns/1ns

module icc_tb;
  import icc_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int SETS       = 1 << IDX_W;
  localparam int N_TESTS    = 6;
  localparam int WD_CYCLES  = 200 * SETS * N_TESTS;
  localparam int TB_MID     = 5;

  logic                                icc_fsm_clk;
  logic                                cpurst_b;
  icc_req_t                            req;
  logic                                pipeline_rdy;
  tag_ram_rsp_t                        tag_rsp   = '0;
  logic                                data_grant = 1'b0;
  logic [LINE_WORDS-1:0][WORD_W-1:0]   data_line = '0;
  logic                                rdl_ready = 1'b0;
  logic                                ready;
  logic                                idle;
  logic                                sweep_cmplt;
  dca_rsp_t                            dca;
  tag_ram_req_t                        tag_req;
  data_ram_req_t                       data_req;
  rdl_req_t                            rdl;

  // RAM model contents
  logic [TAG_W-1:0] tag_mem   [SETS][WAYS];
  logic             vld_mem   [SETS][WAYS];
  logic             dirty_mem [SETS][WAYS];

  integer      seed = 71040;
  logic [31:0] rnd;
  int          n_checks = 0;
  int          n_errors = 0;

  l2c_icc_top #(.IDX_W(IDX_W), .WAYS(WAYS), .TAG_W(TAG_W)) UUT (
    .icc_fsm_clk  (icc_fsm_clk),
    .cpurst_b     (cpurst_b),
    .req          (req),
    .pipeline_rdy (pipeline_rdy),
    .tag_rsp      (tag_rsp),
    .data_grant   (data_grant),
    .data_line    (data_line),
    .rdl_ready    (rdl_ready),
    .ready        (ready),
    .idle         (idle),
    .sweep_cmplt  (sweep_cmplt),
    .dca          (dca),
    .tag_req      (tag_req),
    .data_req     (data_req),
    .rdl          (rdl)
  );

  initial
  begin
    icc_fsm_clk = 1'b0;
    forever #(CLK_PERIOD/2) icc_fsm_clk = ~icc_fsm_clk;
  end

  // ==========================================================================
  // tag and data RAM models, random grants and write-back back-pressure
  // ==========================================================================
  // data fill pattern covers set, way and word
  function automatic logic [WORD_W-1:0] line_word(input int idx, input int way, input int wd);
    return {8'hd5, {(WORD_W-8-IDX_W-WAY_W-OFF_W){1'b0}},
            IDX_W'(idx), WAY_W'(way), OFF_W'(wd)};
  endfunction

  always @(posedge icc_fsm_clk)
  begin
    if (!cpurst_b)
    begin
      for (int s = 0; s < SETS; s++)
      begin
        for (int w = 0; w < WAYS; w++)
        begin
          rnd = $random(seed);
          tag_mem[s][w]   <= rnd[TAG_W-1:0];
          vld_mem[s][w]   <= rnd[TAG_W];
          dirty_mem[s][w] <= rnd[TAG_W+1];
        end
      end
    end
    else
    begin
      if (tag_req.req && tag_rsp.grant)
      begin
        for (int w = 0; w < WAYS; w++)
        begin
          if (tag_req.write && tag_req.way_mask[w])
          begin
            if (tag_req.clr_vld)
              vld_mem[tag_req.index][w] <= 1'b0;
            if (tag_req.clr_dirty)
              dirty_mem[tag_req.index][w] <= 1'b0;
          end
          else if (!tag_req.write)
          begin
            tag_rsp.tag[w]   <= tag_mem[tag_req.index][w];
            tag_rsp.vld[w]   <= vld_mem[tag_req.index][w];
            tag_rsp.dirty[w] <= dirty_mem[tag_req.index][w];
          end
        end
      end
      if (data_req.req && data_grant)
      begin
        for (int wd = 0; wd < LINE_WORDS; wd++)
          data_line[wd] <= line_word(data_req.index, data_req.way, wd);
      end
    end
    rnd = $random(seed);
    tag_rsp.grant <= (rnd[1:0] != 2'b00);
    data_grant    <= (rnd[3:2] != 2'b00);
    rdl_ready     <= rnd[4];
  end

  // ==========================================================================
  // compare tasks
  // ==========================================================================
  task automatic check_bit(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp)
    begin
      n_errors++;
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
                            input logic [WORD_W-1:0] act);
    n_checks++;
    if (act !== exp)
    begin
      n_errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_rdl(input string name, input rdl_req_t exp, input rdl_req_t act);
    n_checks++;
    if (act !== exp)
    begin
      n_errors++;
      $display("FAILED %s: expected addr %h mid %0d, actual addr %h mid %0d",
               name, exp.addr, exp.mid, act.addr, act.mid);
    end
  endtask

  // expected DCA tag word with valid and dirty just above the tag
  function automatic logic [WORD_W-1:0] tag_word(input int idx, input int way);
    logic [WORD_W-1:0] word;
    word            = '0;
    word[TAG_W-1:0] = tag_mem[idx][way];
    word[TAG_W]     = vld_mem[idx][way];
    word[TAG_W+1]   = dirty_mem[idx][way];
    return word;
  endfunction

  // ==========================================================================
  // bus helpers
  // ==========================================================================
  task automatic drive_req(input icc_op_e op, input int idx, input int way, input int off);
    icc_req_t r;
    r.valid  = 1'b1;
    r.op     = op;
    r.way    = WAY_W'(way);
    r.index  = IDX_W'(idx);
    r.offset = OFF_W'(off);
    r.mid    = MID_W'(TB_MID);
    @(posedge icc_fsm_clk);
    req <= r;
  endtask

  // ready seen mid-cycle means acceptance at the next edge
  task automatic wait_accept();
    @(negedge icc_fsm_clk);
    while (!ready)
      @(negedge icc_fsm_clk);
    @(posedge icc_fsm_clk);
    req <= '0;
  endtask

  task automatic run_dca(input string name, input icc_op_e op, input int idx, input int way,
                         input int off, input logic [WORD_W-1:0] exp);
    drive_req(op, idx, way, off);
    wait_accept();
    @(negedge icc_fsm_clk);
    while (!dca.cmplt)
      @(negedge icc_fsm_clk);
    check_word(name, exp, dca.data);
    @(posedge icc_fsm_clk);
  endtask

  // every line of every set comes back invalid and clean
  task automatic run_invalidate(input string name);
    drive_req(ICC_INV_ALL, 0, 0, 0);
    wait_accept();
    @(negedge icc_fsm_clk);
    while (!sweep_cmplt)
      @(negedge icc_fsm_clk);
    // last set write lands on the closing edge
    @(negedge icc_fsm_clk);
    for (int s = 0; s < SETS; s++)
    begin
      for (int w = 0; w < WAYS; w++)
      begin
        check_bit($sformatf("%s valid set %0d way %0d", name, s, w), 1'b0, vld_mem[s][w]);
        check_bit($sformatf("%s dirty set %0d way %0d", name, s, w), 1'b0, dirty_mem[s][w]);
      end
    end
  endtask

  // write-backs go in ascending set order and highest way first within a set
  task automatic run_clean(input string name);
    rdl_req_t exp_q[$];
    rdl_req_t e;
    logic     vld_snap [SETS][WAYS];
    logic     done;
    for (int s = 0; s < SETS; s++)
    begin
      for (int w = WAYS - 1; w >= 0; w--)
      begin
        vld_snap[s][w] = vld_mem[s][w];
        if (vld_mem[s][w] && dirty_mem[s][w])
        begin
          e.valid = 1'b1;
          e.addr  = {tag_mem[s][w], IDX_W'(s)};
          e.mid   = MID_W'(TB_MID);
          exp_q.push_back(e);
        end
      end
    end
    drive_req(ICC_CLN_ALL, 0, 0, 0);
    wait_accept();
    done = 1'b0;
    while (!done)
    begin
      @(negedge icc_fsm_clk);
      if (rdl.valid && rdl_ready)
      begin
        if (exp_q.size() == 0)
        begin
          n_errors++;
          $display("%s: write-back to %h issued with no dirty line left", name, rdl.addr);
        end
        else
          check_rdl(name, exp_q.pop_front(), rdl);
      end
      if (sweep_cmplt)
        done = 1'b1;
    end
    @(posedge icc_fsm_clk);
    if (exp_q.size() != 0)
    begin
      n_errors++;
      $display("%s: sweep ended with %0d write-backs never issued", name, exp_q.size());
    end
    for (int s = 0; s < SETS; s++)
    begin
      for (int w = 0; w < WAYS; w++)
      begin
        check_bit($sformatf("%s dirty set %0d way %0d", name, s, w), 1'b0, dirty_mem[s][w]);
        check_bit($sformatf("%s valid set %0d way %0d", name, s, w), vld_snap[s][w],
                  vld_mem[s][w]);
      end
    end
  endtask

  // ==========================================================================
  // tests
  // ==========================================================================
  task automatic test_reset_state();
    @(negedge icc_fsm_clk);
    check_bit("reset idle", 1'b1, idle);
    check_bit("reset ready", 1'b0, ready);
    check_bit("reset sweep_cmplt", 1'b0, sweep_cmplt);
    check_bit("reset dca cmplt", 1'b0, dca.cmplt);
    check_bit("reset rdl valid", 1'b0, rdl.valid);
    check_bit("reset tag req", 1'b0, tag_req.req);
    check_bit("reset data req", 1'b0, data_req.req);
  endtask

  // request stays valid through the operation so ready must not rise again
  task automatic test_ready_gating();
    logic [WORD_W-1:0] exp;
    exp = tag_word(3, 1);
    @(posedge icc_fsm_clk);
    pipeline_rdy <= 1'b0;
    drive_req(ICC_DCA_TAG, 3, 1, 0);
    repeat (5)
    begin
      @(negedge icc_fsm_clk);
      check_bit("ready with pipeline busy", 1'b0, ready);
    end
    @(posedge icc_fsm_clk);
    pipeline_rdy <= 1'b1;
    @(negedge icc_fsm_clk);
    while (!ready)
      @(negedge icc_fsm_clk);
    @(negedge icc_fsm_clk);
    while (!dca.cmplt)
    begin
      check_bit("ready during operation", 1'b0, ready);
      @(negedge icc_fsm_clk);
    end
    check_bit("ready during operation", 1'b0, ready);
    check_word("dca tag held request", exp, dca.data);
    @(posedge icc_fsm_clk);
    req <= '0;
  endtask

  task automatic test_dca_tag();
    run_dca("dca tag 5/2", ICC_DCA_TAG, 5, 2, 0, tag_word(5, 2));
    run_dca("dca tag 15/0", ICC_DCA_TAG, 15, 0, 0, tag_word(15, 0));
    run_dca("dca tag 10/3", ICC_DCA_TAG, 10, 3, 0, tag_word(10, 3));
  endtask

  task automatic test_dca_data();
    run_dca("dca data 7/3/2", ICC_DCA_DATA, 7, 3, 2, line_word(7, 3, 2));
    run_dca("dca data 0/1/0", ICC_DCA_DATA, 0, 1, 0, line_word(0, 1, 0));
    run_dca("dca data 12/2/3", ICC_DCA_DATA, 12, 2, 3, line_word(12, 2, 3));
  endtask

  task automatic test_inv_then_clean();
    run_invalidate("invalidate-all");
    run_clean("clean after invalidate");
    // valid and dirty both read back as zero
    run_dca("dca tag after inv 6/1", ICC_DCA_TAG, 6, 1, 0, WORD_W'(tag_mem[6][1]));
    run_dca("dca tag after inv 13/3", ICC_DCA_TAG, 13, 3, 0, WORD_W'(tag_mem[13][3]));
  endtask

  initial
  begin
    req          <= '0;
    pipeline_rdy <= 1'b1;
    cpurst_b     <= 1'b0;
    repeat (2) @(posedge icc_fsm_clk);
    cpurst_b <= 1'b1;
    test_reset_state();
    test_ready_gating();
    test_dca_tag();
    test_dca_data();
    run_clean("clean-all");
    test_inv_then_clean();
    repeat (2) @(posedge icc_fsm_clk);
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  // watchdog sized from sweep length and test count
  initial
  begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, a test never finished", WD_CYCLES);
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: sources.f
hw/icc_pkg.sv
hw/icc_req_capture.sv
hw/icc_fsm.sv
hw/icc_dirty_scan.sv
hw/icc_ram_ctrl.sv
hw/icc_dca_read.sv
hw/l2c_icc_top.sv
sim/icc_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing
TOP      = icc_tb
FILELIST = sources.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# output is shown, then searched for the pass message
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
